//--- oooParams.svh
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

////////////////////////////////////////
// Core sizes.
////////////////////////////////////////

// Architectural registers.
`define OOO_NUM_REGS 16

// Register address width.
`define OOO_REG_AW $clog2(`OOO_NUM_REGS)

`define OOO_ROB_DEPTH 8 // Reorder buffer entries.
`define OOO_TAG_W 3     // Buffer index carried on the bus.

// Integer datapath.
`define OOO_DATA_W 32

`endif

//--- oooPkg.sv
package oooPkg;

    `include "oooParams.svh"

    ////////////////////////////////////////
    // Instruction encoding.
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_XOR  = 4'h2,
        OP_ADDI = 4'h3,
        OP_MUL  = 4'h4
    } opcodeT;

    // Opcode selects the view.
    typedef union packed {
        struct packed {
            opcodeT      opcode;
            logic [3:0]  rd;
            logic [3:0]  rs1;
            logic [3:0]  rs2;
            logic [15:0] unused;
        } regForm;
        struct packed {
            opcodeT             opcode;
            logic [3:0]         rd;
            logic [3:0]         rs1;
            logic [3:0]         reserved; // Keeps imm in the low half.
            logic signed [15:0] imm;
        } immForm;
    } instrWordT;

    ////////////////////////////////////////
    // Common data bus.
    ////////////////////////////////////////

    typedef struct packed {
        logic                   valid;
        logic [`OOO_TAG_W-1:0]  tag;
        logic [`OOO_DATA_W-1:0] value;
    } cdbSlotT;

endpackage

//--- cdbIf.sv
`timescale 1ns/1ps
`include "oooParams.svh"

// One strobe per accepted instruction from issue to execute.
interface dispatchIf;
    import oooPkg::*;

    logic                   valid;
    opcodeT                 op;
    logic [`OOO_TAG_W-1:0]  tag;
    logic [`OOO_DATA_W-1:0] operandA;
    logic [`OOO_DATA_W-1:0] operandB;

    modport issue (output valid, op, tag, operandA, operandB);
    modport exec  (input valid, op, tag, operandA, operandB);
endinterface

// Result slots of the ALU and the multiplier.
interface busIf;
    import oooPkg::*;

    cdbSlotT aluSlot;
    cdbSlotT mulSlot;

    modport producer (output aluSlot, mulSlot);
    modport consumer (input aluSlot, mulSlot);
endinterface

//--- issueUnit.sv
`timescale 1ns/1ps
`include "oooParams.svh"

module issueUnit (
    input  logic                    CLK,
    input  logic                    Reset,
    input  logic                    instrValid,
    input  oooPkg::instrWordT       instr,
    output logic                    stall,
    output logic [`OOO_REG_AW-1:0]  rdAddrA,
    output logic [`OOO_REG_AW-1:0]  rdAddrB,
    input  logic [`OOO_DATA_W-1:0]  rdDataA,
    input  logic [`OOO_DATA_W-1:0]  rdDataB,
    input  logic                    full,
    input  logic [`OOO_TAG_W-1:0]   robTail,
    output logic                    append,
    output logic [`OOO_REG_AW-1:0]  destReg,
    output logic                    writeBack,
    input  logic                    commitWe,
    input  logic [`OOO_REG_AW-1:0]  commitAddr,
    dispatchIf.issue                dispatch
);
    import oooPkg::*;

    logic [`OOO_NUM_REGS-1:0] pending; // Register has an older write in flight.
    opcodeT                   op;
    logic                     isImm;
    logic [`OOO_REG_AW-1:0]   rd;
    logic [`OOO_REG_AW-1:0]   rs1;
    logic [`OOO_REG_AW-1:0]   rs2;
    logic                     srcPending;
    logic                     destPending;
    logic                     accept;
    logic [`OOO_DATA_W-1:0]   immExt;

    ////////////////////////////////////////
    // Decode.
    ////////////////////////////////////////

    assign op    = instr.regForm.opcode;
    assign isImm = (op == OP_ADDI);
    assign rd    = instr.regForm.rd;
    assign rs1   = instr.regForm.rs1;
    assign rs2   = isImm ? '0 : instr.regForm.rs2; // No second source.

    assign immExt = {{(`OOO_DATA_W-16){instr.immForm.imm[15]}}, instr.immForm.imm};

    assign rdAddrA = rs1;
    assign rdAddrB = rs2;

    // Hazards against older writes.
    assign srcPending  = pending[rs1] | pending[rs2];
    assign destPending = pending[rd] & (rd != '0);
    assign stall       = full | srcPending | destPending;

    assign accept    = instrValid & ~stall;
    assign append    = accept;
    assign destReg   = rd;
    assign writeBack = (rd != '0);

    ////////////////////////////////////////
    // Scoreboard and dispatch strobe.
    ////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            pending        <= '0;
            dispatch.valid <= 1'b0;
        end else begin
            dispatch.valid <= accept;
            if (commitWe) begin
                pending[commitAddr] <= 1'b0;
            end
            if (accept && writeBack) begin
                pending[rd] <= 1'b1;
            end
        end
    end

    // Operands straight from the committed file.
    always_ff @(posedge CLK) begin
        if (accept) begin
            dispatch.op       <= op;
            dispatch.tag      <= robTail;
            dispatch.operandA <= rdDataA;
            dispatch.operandB <= isImm ? immExt : rdDataB;
        end
    end

endmodule

//--- multiplyPipe.sv
`timescale 1ns/1ps
`include "oooParams.svh"

module multiplyPipe (
    input  logic                    CLK,
    input  logic                    Reset,
    input  logic                    inValid,
    input  logic [`OOO_TAG_W-1:0]   inTag,
    input  logic [`OOO_DATA_W-1:0]  a,
    input  logic [`OOO_DATA_W-1:0]  b,
    output oooPkg::cdbSlotT         outSlot
);

    logic                   valid1, valid2, valid3;
    logic [`OOO_TAG_W-1:0]  tag1, tag2, tag3;
    logic [`OOO_DATA_W-1:0] lowProd1;  // a.lo * b.lo.
    logic [15:0]            crossSum1; // Only its low half reaches the result.
    logic [`OOO_DATA_W-1:0] prod2;
    logic [`OOO_DATA_W-1:0] prod3;

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
        end else begin
            valid1 <= inValid;
            valid2 <= valid1;
            valid3 <= valid2;
        end
    end

    // Partial products, then sum, then output register.
    always_ff @(posedge CLK) begin
        tag1      <= inTag;
        lowProd1  <= a[15:0] * b[15:0];
        crossSum1 <= a[15:0] * b[31:16] + a[31:16] * b[15:0];
        tag2      <= tag1;
        prod2     <= lowProd1 + {crossSum1, 16'h0000};
        tag3      <= tag2;
        prod3     <= prod2;
    end

    assign outSlot = '{valid: valid3, tag: tag3, value: prod3};

endmodule

//--- execCluster.sv
`timescale 1ns/1ps
`include "oooParams.svh"

module execCluster (
    input  logic         CLK,
    input  logic         Reset,
    dispatchIf.exec      dispatch,
    busIf.producer       bus
);
    import oooPkg::*;

    logic                   isMul;
    logic                   aluGo;
    logic [`OOO_DATA_W-1:0] aluResult;
    logic                   aluValid;
    logic [`OOO_TAG_W-1:0]  aluTag;
    logic [`OOO_DATA_W-1:0] aluValue;

    ////////////////////////////////////////
    // Unit select.
    ////////////////////////////////////////

    assign isMul = (dispatch.op == OP_MUL);
    assign aluGo = dispatch.valid & ~isMul;

    ////////////////////////////////////////
    // Single-cycle ALU.
    ////////////////////////////////////////

    always_comb begin
        case (dispatch.op)
            OP_SUB:  aluResult = dispatch.operandA - dispatch.operandB;
            OP_XOR:  aluResult = dispatch.operandA ^ dispatch.operandB;
            default: aluResult = dispatch.operandA + dispatch.operandB; // ADD, ADDI.
        endcase
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            aluValid <= 1'b0;
        end else begin
            aluValid <= aluGo;
        end
    end

    always_ff @(posedge CLK) begin
        if (aluGo) begin
            aluTag   <= dispatch.tag;
            aluValue <= aluResult;
        end
    end

    assign bus.aluSlot = '{valid: aluValid, tag: aluTag, value: aluValue};

    ////////////////////////////////////////
    // Pipelined multiplier.
    ////////////////////////////////////////

    multiplyPipe multiplyPipe_i (
        .CLK     (CLK),
        .Reset   (Reset),
        .inValid (dispatch.valid & isMul),
        .inTag   (dispatch.tag),
        .a       (dispatch.operandA),
        .b       (dispatch.operandB),
        .outSlot (bus.mulSlot)
    );

endmodule

//--- reorderBuffer.sv
`timescale 1ns/1ps
`include "oooParams.svh"

module reorderBuffer (
    input  logic                    CLK,
    input  logic                    Reset,
    input  logic                    append,
    input  logic [`OOO_REG_AW-1:0]  destReg,
    input  logic                    writeBack,
    output logic                    full,
    output logic [`OOO_TAG_W-1:0]   robTail,
    busIf.consumer                  bus,
    output logic                    commitWe,
    output logic [`OOO_REG_AW-1:0]  commitAddr,
    output logic [`OOO_DATA_W-1:0]  commitData
);
    import oooPkg::*;

    // Extra pointer bit separates full from empty.
    logic [`OOO_TAG_W:0]    head;
    logic [`OOO_TAG_W:0]    tail;
    logic [`OOO_TAG_W-1:0]  headIdx;
    logic [`OOO_TAG_W-1:0]  tailIdx;

    logic [`OOO_ROB_DEPTH-1:0] busy;
    logic [`OOO_ROB_DEPTH-1:0] done;  // Result captured.
    logic [`OOO_REG_AW-1:0]    dest  [`OOO_ROB_DEPTH];
    logic                      wbFlag [`OOO_ROB_DEPTH];
    logic [`OOO_DATA_W-1:0]    value [`OOO_ROB_DEPTH];

    cdbSlotT slots [2];
    logic    retire;

    assign headIdx = head[`OOO_TAG_W-1:0];
    assign tailIdx = tail[`OOO_TAG_W-1:0];
    assign robTail = tailIdx;

    assign full = (head[`OOO_TAG_W] != tail[`OOO_TAG_W]) && (headIdx == tailIdx);

    assign slots[0] = bus.aluSlot;
    assign slots[1] = bus.mulSlot;

    assign retire = busy[headIdx] & done[headIdx];

    ////////////////////////////////////////
    // Allocation and result capture.
    ////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            tail <= '0;
            busy <= '0;
            done <= '0;
        end else begin
            if (append) begin
                tail          <= tail + 1'b1;
                busy[tailIdx] <= 1'b1;
                done[tailIdx] <= 1'b0;
            end
            if (retire) begin
                busy[headIdx] <= 1'b0;
            end
            for (int i = 0; i < 2; i++) begin
                if (slots[i].valid && busy[slots[i].tag]) begin
                    done[slots[i].tag] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (append) begin
            dest[tailIdx]   <= destReg;
            wbFlag[tailIdx] <= writeBack;
        end
        for (int i = 0; i < 2; i++) begin
            if (slots[i].valid && busy[slots[i].tag]) begin
                value[slots[i].tag] <= slots[i].value;
            end
        end
    end

    ////////////////////////////////////////
    // In-order commit.
    ////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            head       <= '0;
            commitWe   <= 1'b0;
            commitAddr <= '0;
            commitData <= '0;
        end else if (retire) begin
            head       <= head + 1'b1;
            commitWe   <= wbFlag[headIdx];
            commitAddr <= dest[headIdx];
            commitData <= value[headIdx];
        end else begin
            commitWe   <= 1'b0; // Outputs pulse only.
            commitAddr <= '0;
            commitData <= '0;
        end
    end

endmodule

//--- registerFile.sv
`timescale 1ns/1ps
`include "oooParams.svh"

module registerFile (
    input  logic                    CLK,
    input  logic                    Reset,
    input  logic [`OOO_REG_AW-1:0]  rdAddrA,
    input  logic [`OOO_REG_AW-1:0]  rdAddrB,
    output logic [`OOO_DATA_W-1:0]  rdDataA,
    output logic [`OOO_DATA_W-1:0]  rdDataB,
    input  logic                    commitWe,
    input  logic [`OOO_REG_AW-1:0]  commitAddr,
    input  logic [`OOO_DATA_W-1:0]  commitData
);

    logic [`OOO_DATA_W-1:0] regs [`OOO_NUM_REGS];

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commitWe && commitAddr != '0) begin
            regs[commitAddr] <= commitData;
        end
    end

    // Register 0 is hardwired.
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- oooCore.sv
`timescale 1ns/1ps
`include "oooParams.svh"

module oooCore (
    input  logic                    CLK,
    input  logic                    Reset,
    input  logic                    instrValid,
    input  logic [31:0]             instr,
    output logic                    stall,
    output logic                    commitWe,
    output logic [`OOO_REG_AW-1:0]  commitAddr,
    output logic [`OOO_DATA_W-1:0]  commitData
);
    import oooPkg::*;

    instrWordT              instrWord;
    logic [`OOO_REG_AW-1:0] rdAddrA;
    logic [`OOO_REG_AW-1:0] rdAddrB;
    logic [`OOO_DATA_W-1:0] rdDataA;
    logic [`OOO_DATA_W-1:0] rdDataB;
    logic                   full;
    logic [`OOO_TAG_W-1:0]  robTail;
    logic                   append;
    logic [`OOO_REG_AW-1:0] destReg;
    logic                   writeBack;

    dispatchIf dispatchBus ();
    busIf      cdb ();

    assign instrWord = instr;

    ////////////////////////////////////////
    // Issue, execute, retire.
    ////////////////////////////////////////

    issueUnit issueUnit_i (
        .CLK        (CLK),
        .Reset      (Reset),
        .instrValid (instrValid),
        .instr      (instrWord),
        .stall      (stall),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .full       (full),
        .robTail    (robTail),
        .append     (append),
        .destReg    (destReg),
        .writeBack  (writeBack),
        .commitWe   (commitWe),
        .commitAddr (commitAddr),
        .dispatch   (dispatchBus)
    );

    execCluster execCluster_i (
        .CLK      (CLK),
        .Reset    (Reset),
        .dispatch (dispatchBus),
        .bus      (cdb)
    );

    reorderBuffer reorderBuffer_i (
        .CLK        (CLK),
        .Reset      (Reset),
        .append     (append),
        .destReg    (destReg),
        .writeBack  (writeBack),
        .full       (full),
        .robTail    (robTail),
        .bus        (cdb),
        .commitWe   (commitWe),
        .commitAddr (commitAddr),
        .commitData (commitData)
    );

    registerFile registerFile_i (
        .CLK        (CLK),
        .Reset      (Reset),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .commitWe   (commitWe),
        .commitAddr (commitAddr),
        .commitData (commitData)
    );

endmodule

//--- oooCoreAssert.sv
`timescale 1ns/1ps
`include "oooParams.svh"

module oooCoreAssert (
    input logic                   CLK,
    input logic                   Reset,
    input logic                   commitWe,
    input logic [`OOO_REG_AW-1:0] commitAddr,
    input logic                   append,
    input logic                   full,
    input oooPkg::cdbSlotT        aluSlot,
    input oooPkg::cdbSlotT        mulSlot
);

    // Register 0 never takes a write.
    commitNonZero: assert property (@(posedge CLK) disable iff (Reset)
        commitWe |-> commitAddr != '0)
        else $error("commit write strobe with register address 0");

    noAppendWhenFull: assert property (@(posedge CLK) disable iff (Reset)
        !(append && full))
        else $error("reorder buffer append while full");

    distinctSlotTags: assert property (@(posedge CLK) disable iff (Reset)
        !(aluSlot.valid && mulSlot.valid && aluSlot.tag == mulSlot.tag))
        else $error("both bus slots carry tag %0d", aluSlot.tag);

endmodule

bind oooCore oooCoreAssert coreChecks_i (
    .CLK        (CLK),
    .Reset      (Reset),
    .commitWe   (commitWe),
    .commitAddr (commitAddr),
    .append     (append),
    .full       (full),
    .aluSlot    (cdb.aluSlot),
    .mulSlot    (cdb.mulSlot)
);

bind reorderBuffer oooCoreAssert robChecks_i (
    .CLK        (CLK),
    .Reset      (Reset),
    .commitWe   (commitWe),
    .commitAddr (commitAddr),
    .append     (append),
    .full       (full),
    .aluSlot    (slots[0]),
    .mulSlot    (slots[1])
);

//--- oooCoreTb.sv
`timescale 1ns/1ps
`include "oooParams.svh"

module oooCoreTb;
    import oooPkg::*;

    localparam int MaxEntries = 64;
    localparam int NumTests   = 6;

    logic                   CLK;
    logic                   Reset;
    logic                   instrValid;
    logic [31:0]            instr;
    logic                   stall;
    logic                   commitWe;
    logic [`OOO_REG_AW-1:0] commitAddr;
    logic [`OOO_DATA_W-1:0] commitData;

    opcodeT      opTab   [MaxEntries];
    logic [3:0]  rdTab   [MaxEntries];
    logic [3:0]  rs1Tab  [MaxEntries];
    logic [15:0] srcTab  [MaxEntries]; // rs2, or the ADDI immediate.
    int          testTab [MaxEntries];
    int          numEntries;

    string testNames   [NumTests];
    int    testErrors  [NumTests];
    int    testCommits [NumTests];

    // Reference registers and the commit stream still owed.
    logic [31:0] modelRegs [16];
    logic [3:0]  expAddr [$];
    logic [31:0] expData [$];
    int          expTest [$];

    int errorCount;
    int commitCount;
    int cycleCount;
    int timeoutLimit;
    int seed;

    oooCore oooCore_i (
        .CLK        (CLK),
        .Reset      (Reset),
        .instrValid (instrValid),
        .instr      (instr),
        .stall      (stall),
        .commitWe   (commitWe),
        .commitAddr (commitAddr),
        .commitData (commitData)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    ////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////

    task automatic compareValue(input int testIdx, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: %s expected 0x%08h actual 0x%08h",
                     testNames[testIdx], what, expected, actual);
            errorCount++;
            testErrors[testIdx]++;
        end
    endtask

    task automatic addEntry(input opcodeT op, input logic [3:0] rd, input logic [3:0] rs1,
                            input logic [15:0] src, input int testIdx);
        opTab[numEntries]   = op;
        rdTab[numEntries]   = rd;
        rs1Tab[numEntries]  = rs1;
        srcTab[numEntries]  = src;
        testTab[numEntries] = testIdx;
        numEntries++;
    endtask

    function automatic logic [31:0] encodeEntry(input int idx);
        instrWordT w;
        w = '0;
        if (opTab[idx] == OP_ADDI) begin
            w.immForm.opcode = opTab[idx];
            w.immForm.rd     = rdTab[idx];
            w.immForm.rs1    = rs1Tab[idx];
            w.immForm.imm    = srcTab[idx];
        end else begin
            w.regForm.opcode = opTab[idx];
            w.regForm.rd     = rdTab[idx];
            w.regForm.rs1    = rs1Tab[idx];
            w.regForm.rs2    = srcTab[idx][3:0];
        end
        return w;
    endfunction

    // Any source or destination still waiting on an older write.
    function automatic logic hazardPending(input int idx);
        logic [3:0] rs2;
        logic       hit;
        rs2 = (opTab[idx] == OP_ADDI) ? 4'd0 : srcTab[idx][3:0];
        hit = 1'b0;
        for (int k = 0; k < expAddr.size(); k++) begin
            if (expAddr[k] == rs1Tab[idx] || expAddr[k] == rs2 ||
                expAddr[k] == rdTab[idx]) begin
                hit = 1'b1;
            end
        end
        // Scoreboard clears one edge after the commit pulse.
        if (commitWe && commitAddr != 4'd0 &&
            (commitAddr == rs1Tab[idx] || commitAddr == rs2 || commitAddr == rdTab[idx])) begin
            hit = 1'b1;
        end
        return hit;
    endfunction

    // Program-order result with register 0 held at zero.
    task automatic recordAccept(input int idx);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        a = modelRegs[rs1Tab[idx]];
        b = (opTab[idx] == OP_ADDI) ? {{16{srcTab[idx][15]}}, srcTab[idx]}
                                    : modelRegs[srcTab[idx][3:0]];
        case (opTab[idx])
            OP_SUB:  result = a - b;
            OP_XOR:  result = a ^ b;
            OP_MUL:  result = a * b; // Low 32 bits only.
            default: result = a + b;
        endcase
        if (rdTab[idx] != 4'd0) begin
            modelRegs[rdTab[idx]] = result;
            expAddr.push_back(rdTab[idx]);
            expData.push_back(result);
            expTest.push_back(testTab[idx]);
        end
    endtask

    // Called 1 ns after an edge; holds the word until an edge accepts it.
    task automatic issueEntry(input int idx);
        logic accepted;
        accepted   = 1'b0;
        instr      = encodeEntry(idx);
        instrValid = 1'b1;
        while (!accepted) begin
            #2;
            if (hazardPending(idx)) begin
                compareValue(testTab[idx], "stall on hazard", 32'd1, 32'(stall));
            end
            accepted = !stall;
            @(posedge CLK);
            #1;
        end
        recordAccept(idx);
        instrValid = 1'b0;
    endtask

    task automatic reportTest(input int testIdx);
        $display("test %s: %0d commits, %0d errors",
                 testNames[testIdx], testCommits[testIdx], testErrors[testIdx]);
    endtask

    ////////////////////////////////////////
    // Stimulus table.
    ////////////////////////////////////////

    task automatic buildTable();
        int r;
        numEntries = 0;
        addEntry(OP_ADDI, 1, 0, 16'd5, 1);   // Dependent ALU chain.
        addEntry(OP_ADDI, 2, 0, 16'hFFFD, 1);
        addEntry(OP_ADD, 3, 1, 2, 1);
        addEntry(OP_SUB, 4, 3, 1, 1);
        addEntry(OP_XOR, 5, 1, 4, 1);
        addEntry(OP_ADD, 6, 5, 5, 1);
        addEntry(OP_MUL, 7, 1, 2, 2);        // Slow head, fast followers.
        addEntry(OP_ADDI, 8, 0, 16'd100, 2);
        addEntry(OP_ADDI, 9, 1, 16'd7, 2);
        addEntry(OP_ADDI, 10, 2, 16'd1, 2);
        addEntry(OP_ADD, 11, 8, 9, 2);
        addEntry(OP_MUL, 4, 1, 2, 3);        // Independent burst.
        addEntry(OP_ADDI, 5, 3, 16'd11, 3);
        addEntry(OP_MUL, 6, 2, 3, 3);
        addEntry(OP_ADDI, 7, 1, 16'hFFEC, 3);
        addEntry(OP_MUL, 8, 1, 3, 3);
        addEntry(OP_ADDI, 9, 2, 16'd300, 3);
        addEntry(OP_MUL, 10, 3, 3, 3);
        addEntry(OP_ADDI, 11, 3, 16'hFFFF, 3);
        addEntry(OP_MUL, 12, 1, 1, 3);
        addEntry(OP_ADDI, 13, 2, 16'd42, 3);
        addEntry(OP_ADDI, 0, 1, 16'd99, 4);  // No write for rd 0.
        addEntry(OP_ADD, 0, 2, 3, 4);
        addEntry(OP_ADD, 14, 0, 3, 4);
        addEntry(OP_MUL, 0, 1, 2, 4);
        addEntry(OP_SUB, 15, 14, 0, 4);
        for (int i = 1; i <= 4; i++) begin
            r = $random(seed);
            addEntry(OP_ADDI, i[3:0], 0, r[15:0], 5);
        end
        addEntry(OP_MUL, 5, 1, 2, 5);
        addEntry(OP_MUL, 6, 3, 4, 5);
        addEntry(OP_MUL, 7, 1, 3, 5);
        addEntry(OP_MUL, 8, 2, 4, 5);
        addEntry(OP_MUL, 9, 5, 6, 5);
    endtask

    ////////////////////////////////////////
    // Commit monitor and timeout.
    ////////////////////////////////////////

    always @(negedge CLK) begin
        if (!Reset && commitWe) begin
            if (expAddr.size() == 0) begin
                $display("Commit to register %0d arrived with no instruction outstanding",
                         commitAddr);
                errorCount++;
            end else begin
                compareValue(expTest[0], "commit address", 32'(expAddr[0]), 32'(commitAddr));
                compareValue(expTest[0], "commit data", expData[0], commitData);
                testCommits[expTest[0]]++;
                commitCount++;
                void'(expAddr.pop_front());
                void'(expData.pop_front());
                void'(expTest.pop_front());
            end
        end
    end

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////

    initial begin
        int entry;
        Reset       = 1'b1;
        instrValid  = 1'b0;
        instr       = '0;
        errorCount  = 0;
        commitCount = 0;
        cycleCount  = 0;
        seed        = 19;
        testNames   = '{"idleAfterReset", "aluChain", "mulThenAddi",
                        "burstFill", "zeroReg", "randomMul"};
        for (int i = 0; i < NumTests; i++) begin
            testErrors[i]  = 0;
            testCommits[i] = 0;
        end
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
        buildTable();
        timeoutLimit = 8 * numEntries + 100;

        repeat (8) @(posedge CLK);
        #1 Reset = 1'b0;

        repeat (10) begin
            @(negedge CLK);
            compareValue(0, "stall", 32'd0, 32'(stall));
            compareValue(0, "commitWe", 32'd0, 32'(commitWe));
        end
        reportTest(0);
        @(posedge CLK);
        #1;

        entry = 0;
        for (int t = 1; t < NumTests; t++) begin
            while (entry < numEntries && testTab[entry] == t) begin
                issueEntry(entry);
                entry++;
            end
            do @(posedge CLK); while (expAddr.size() != 0);
            #1;
            reportTest(t);
        end
        repeat (10) @(posedge CLK); // Catch stray commits.

        $display("Tests %0d, commits %0d, errors %0d", NumTests, commitCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
oooPkg.sv
cdbIf.sv
issueUnit.sv
multiplyPipe.sv
execCluster.sv
reorderBuffer.sv
registerFile.sv
oooCore.sv
oooCoreAssert.sv
oooCoreTb.sv

//--- Makefile
TOP = oooCoreTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
